// ==== run_verilator.sh ====
#!/usr/bin/env bash
# Build and run tb_rv_core with Verilator; the log is scanned for the fail message
set -u

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_rv_core \
  --Mdir obj_dir -o Vtb_rv_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv_core +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// ==== tb/rv_core_assert.sv ====
// Protocol checker bound into rv_core; counts failures in fail_cnt so the testbench can stop the run
`timescale 1ns/1ps
module rv_core_assert (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Instruction stream
  input  logic                 instr_ready_i,
  // Retire stream
  input  logic                 retire_valid_i,
  input  logic                 retire_ready_i,
  input  rv_core_pkg::retire_t retire_i
);
  import rv_core_pkg::*;

  // Read by the testbench top
  int fail_cnt = 0;

  ////////////////////
  // Reset state
  ////////////////////
  a_reset_idle: assert property (@(posedge clk_i)
    !arst_n_i |-> !retire_valid_i && instr_ready_i)
  else begin
    $error("retire stream active or instruction stream blocked during reset");
    fail_cnt++;
  end

  ////////////////////
  // Retire stream
  ////////////////////
  // Stalled item stays offered
  a_retire_valid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    retire_valid_i && !retire_ready_i |=> retire_valid_i)
  else begin
    $error("retire_valid dropped before its transfer");
    fail_cnt++;
  end

  // Payload frozen too
  a_retire_data_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    retire_valid_i && !retire_ready_i |=> $stable(retire_i))
  else begin
    $error("retire payload changed while stalled");
    fail_cnt++;
  end

  // Input blocks only behind a stalled retire
  a_instr_ready_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !instr_ready_i |-> retire_valid_i && !retire_ready_i)
  else begin
    $error("instruction stream blocked without a stalled retire");
    fail_cnt++;
  end

endmodule

bind rv_core rv_core_assert u_core_assert (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .instr_ready_i  (instr_ready_o),
  .retire_valid_i (retire_valid_o),
  .retire_ready_i (retire_ready_i),
  .retire_i       (retire_o)
);

// ==== tb/tb_rv_core.sv ====
// Random OP, OP-IMM, LUI and illegal words; fixed seed, expects in-order retire of every word
`timescale 1ns/1ps
module tb_rv_core;
  import rv_core_pkg::*;

  localparam int          CLK_PERIOD      = 100;
  localparam int          RST_CYCLES      = 3;
  localparam int          N_INSTR         = 400;
  localparam int unsigned SEED            = 32'h4879_17a4;
  // Generous bound, even a stalled pipe retires far more than one word per 8 cycles
  localparam int          WATCHDOG_CYCLES = N_INSTR * 8 + 20;

  logic    clk_i;
  logic    arst_n_i;
  logic    instr_valid_i;
  logic    instr_ready_o;
  instr_u  instr_i;
  logic    retire_valid_o;
  logic    retire_ready_i;
  retire_t retire_o;

  // Sequential model of the architectural registers
  logic [XLEN-1:0] model_regs [0:31] = '{default: '0};
  retire_t         exp_q [$];

  rv_core i_dut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_i        (instr_i),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // RV32I semantics selected by funct3, alt picks SUB or SRA
  function automatic logic [XLEN-1:0] compute_alu(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
    logic [XLEN-1:0] res;
    case (f3)
      3'd0:    res = alt ? a - b : a + b;
      3'd1:    res = a << b[4:0];
      3'd2:    res = {31'b0, $signed(a) < $signed(b)};
      3'd3:    res = {31'b0, a < b};
      3'd4:    res = a ^ b;
      3'd5:    res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // Executes one accepted word in order and queues its retire record
  task automatic accept_instr(input instr_u w);
    retire_t         exp;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic            ok;
    exp = '0;
    f3  = w.r_type.funct3;
    f7  = w.r_type.funct7;
    a   = model_regs[w.r_type.rs1];
    ok  = 1'b1;
    case (w.r_type.opcode)
      OPCODE_OP: begin
        b  = model_regs[w.r_type.rs2];
        // Alternate funct7 only for SUB and SRA
        ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        exp.result = compute_alu(f3, f7[5], a, b);
      end
      OPCODE_OP_IMM: begin
        b  = {{20{w.i_type.imm[11]}}, w.i_type.imm};
        // imm[11:5] picks the shift kind
        ok = !(((f3 == 3'd1) && (f7 != 7'h00)) ||
               ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20)));
        exp.result = compute_alu(f3, (f3 == 3'd5) && f7[5], a, b);
      end
      OPCODE_LUI: begin
        exp.result = {w[31:12], 12'h000};
      end
      default: begin
        ok = 1'b0;
      end
    endcase
    exp.rd      = w.r_type.rd;
    exp.rd_we   = ok;
    exp.illegal = !ok;
    if (!ok) begin
      exp.result = '0;
    end else if (exp.rd != '0) begin
      model_regs[exp.rd] = exp.result;
    end
    exp_q.push_back(exp);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  // Mostly x0..x3 so that neighbours depend on each other
  function automatic logic [REG_ADDR_W-1:0] pick_reg();
    if ($urandom_range(9) < 8) begin
      return 5'($urandom_range(3));
    end
    return 5'($urandom_range(31));
  endfunction

  function automatic instr_u random_instr();
    instr_u      w;
    int unsigned kind;
    logic [2:0]  f3;
    kind         = $urandom_range(99);
    f3           = 3'($urandom_range(7));
    w            = '0;
    w.r_type.rd  = pick_reg();
    w.r_type.rs1 = pick_reg();
    if (kind < 45) begin
      w.r_type.opcode = OPCODE_OP;
      w.r_type.funct3 = f3;
      w.r_type.rs2    = pick_reg();
      if (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(1) == 1)) begin
        w.r_type.funct7 = 7'h20;
      end
    end else if (kind < 80) begin
      w.i_type.opcode = OPCODE_OP_IMM;
      w.i_type.funct3 = f3;
      w.i_type.imm    = 12'($urandom);
      if (f3 == 3'd1) begin
        w.r_type.funct7 = 7'h00;
      end
      if (f3 == 3'd5) begin
        w.r_type.funct7 = ($urandom_range(1) == 1) ? 7'h20 : 7'h00;
      end
    end else if (kind < 92) begin
      w = {20'($urandom), w.r_type.rd, OPCODE_LUI};
    end else begin
      // Dropped load opcode, or OP with an unused funct7
      w = $urandom;
      if ($urandom_range(1) == 1) begin
        w.r_type.opcode = OPCODE_OP;
        w.r_type.funct7 = 7'h7f;
      end else begin
        w.r_type.opcode = 7'b0000011;
      end
    end
    return w;
  endfunction

  // Valid drops at random, a raised word waits for its transfer
  task automatic drive_stream();
    int   issued;
    logic busy;
    issued = 0;
    busy   = 1'b0;
    while ((issued < N_INSTR) || busy) begin
      @(posedge clk_i);
      if (busy && instr_ready_o) begin
        accept_instr(instr_i);
        busy = 1'b0;
      end
      if (!busy) begin
        if ((issued < N_INSTR) && ($urandom_range(3) != 0)) begin
          instr_i       <= random_instr();
          instr_valid_i <= 1'b1;
          issued++;
          busy = 1'b1;
        end else begin
          instr_valid_i <= 1'b0;
        end
      end
    end
  endtask

  // Low runs of one to five cycles
  task automatic drive_retire_ready();
    forever begin
      @(posedge clk_i);
      if ($urandom_range(7) == 0) begin
        retire_ready_i <= 1'b0;
        repeat ($urandom_range(5, 1)) @(posedge clk_i);
      end
      retire_ready_i <= 1'b1;
    end
  endtask

  task automatic check_idle();
    assert ((retire_valid_o == 1'b0) && (instr_ready_o == 1'b1)) else begin
      $display("[ERROR] retire_valid_o = %h (expected 0), instr_ready_o = %h (expected 1)",
               retire_valid_o, instr_ready_o);
      abort_run();
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////
  always @(posedge clk_i) begin
    retire_t exp;
    if (arst_n_i && retire_valid_o && retire_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A retire transfer happened with no accepted instruction left");
        abort_run();
      end else begin
        exp = exp_q.pop_front();
        assert (retire_o == exp) else begin
          $display("[ERROR] retire_o = %h, expected %h", retire_o, exp);
          $display("  result %h vs %h, rd %h vs %h, rd_we %h vs %h, illegal %h vs %h",
                   retire_o.result, exp.result, retire_o.rd, exp.rd,
                   retire_o.rd_we, exp.rd_we, retire_o.illegal, exp.illegal);
          abort_run();
        end
      end
    end
  end

  // Bound protocol checker
  always @(posedge clk_i) begin
    assert (i_dut.u_core_assert.fail_cnt == 0) else begin
      $display("A protocol assertion on the DUT ports failed");
      abort_run();
    end
  end

  initial begin
    void'($urandom(SEED));
    arst_n_i       <= 1'b0;
    instr_valid_i  <= 1'b0;
    instr_i        <= '0;
    retire_ready_i <= 1'b1;
    fork
      drive_retire_ready();
      begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all instructions retired");
        abort_run();
      end
    join_none
    repeat (RST_CYCLES) begin
      @(posedge clk_i);
      check_idle();
    end
    arst_n_i <= 1'b1;
    // First cycle out of reset
    @(posedge clk_i);
    check_idle();
    drive_stream();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    // Room for a stray extra retire
    repeat (5) @(posedge clk_i);
    if (retire_valid_o) begin
      $display("[ERROR] retire_valid_o = %h after the last expected retire", retire_valid_o);
      abort_run();
    end else if (i_dut.u_core_assert.fail_cnt != 0) begin
      $display("A protocol assertion on the DUT ports failed");
      abort_run();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== verilog/rv_core.sv ====
// Three-stage ALU pipeline fed by an instruction stream; no fetch, PC, memory or traps
`timescale 1ns/1ps
module rv_core (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Instruction stream in
  input  logic                 instr_valid_i,
  output logic                 instr_ready_o,
  input  rv_core_pkg::instr_u  instr_i,
  // Retire stream out
  output logic                 retire_valid_o,
  input  logic                 retire_ready_i,
  output rv_core_pkg::retire_t retire_o
);
  import rv_core_pkg::*;

  // ID/EX handshake
  logic                  id_valid;
  logic                  ex_ready;
  id_ex_t                id_ex;
  // EX/WB handshake
  logic                  ex_valid;
  logic                  wb_ready;
  ex_wb_t                ex_wb;
  // Forwarding
  ex_wb_t                fwd_ex;
  ex_wb_t                fwd_wb;
  // Register file ports
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  ////////////////////
  // ID stage
  ////////////////////
  rv_id_stage u_id_stage (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_i        (instr_i),
    .rf_raddr_a_o   (rf_raddr_a),
    .rf_raddr_b_o   (rf_raddr_b),
    .rf_rdata_a_i   (rf_rdata_a),
    .rf_rdata_b_i   (rf_rdata_b),
    .fwd_ex_i       (fwd_ex),
    .fwd_wb_i       (fwd_wb),
    // EX holds an item exactly when ID/EX is valid
    .fwd_ex_valid_i (id_valid),
    .fwd_wb_valid_i (ex_valid),
    .id_valid_o     (id_valid),
    .ex_ready_i     (ex_ready),
    .id_ex_o        (id_ex)
  );

  // EX stage
  rv_ex_stage u_ex_stage (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .id_valid_i (id_valid),
    .ex_ready_o (ex_ready),
    .id_ex_i    (id_ex),
    .ex_valid_o (ex_valid),
    .wb_ready_i (wb_ready),
    .ex_wb_o    (ex_wb),
    .fwd_ex_o   (fwd_ex)
  );

  // WB stage
  rv_wb_stage u_wb_stage (
    .ex_valid_i     (ex_valid),
    .wb_ready_o     (wb_ready),
    .ex_wb_i        (ex_wb),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .fwd_wb_o       (fwd_wb)
  );

  ////////////////////
  // Register file
  ////////////////////
  rv_register_file u_register_file (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

endmodule

// ==== verilog/rv_core_pkg.sv ====
// RV32I subset only (OP, OP-IMM, LUI); no loads, stores, branches, CSRs or compressed code
package rv_core_pkg;

  // Datapath widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes still decoded
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

  // funct7 values for the OP group and immediate shifts
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // ALU operations executed in EX
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // Register-register view
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  // Immediate view, LUI reuses imm/rs1/funct3 as its upper 20 bits
  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  // One instruction word, two decodings
  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
  } instr_u;

  ////////////////////
  // Pipeline payloads
  ////////////////////

  // ID to EX
  typedef struct packed {
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic                  illegal;
  } id_ex_t;

  // EX to WB, also the forwarding bundle
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [XLEN-1:0]       result;
    logic                  illegal;
  } ex_wb_t;

  // Retire stream payload, same layout as ex_wb_t
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [XLEN-1:0]       result;
    logic                  illegal;
  } retire_t;

endpackage

// ==== verilog/rv_ex_stage.sv ====
// Single-cycle ALU; shifts use operand_b[4:0], illegal items always produce zero
`timescale 1ns/1ps
module rv_ex_stage (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // ID/EX handshake
  input  logic                id_valid_i,
  output logic                ex_ready_o,
  input  rv_core_pkg::id_ex_t id_ex_i,
  // EX/WB handshake
  output logic                ex_valid_o,
  input  logic                wb_ready_i,
  output rv_core_pkg::ex_wb_t ex_wb_o,
  // Result of the item in EX, for ID
  output rv_core_pkg::ex_wb_t fwd_ex_o
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  ex_wb_t          ex_wb_d;
  ex_wb_t          ex_wb_q;
  logic            ex_valid_q;

  ////////////////////
  // ALU
  ////////////////////
  assign shamt       = id_ex_i.operand_b[4:0];
  assign lt_signed   = $signed(id_ex_i.operand_a) < $signed(id_ex_i.operand_b);
  assign lt_unsigned = id_ex_i.operand_a < id_ex_i.operand_b;

  always_comb begin
    alu_result = '0;
    case (id_ex_i.alu_op)
      ALU_ADD:  alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB:  alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND:  alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:   alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR:  alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      ALU_SLL:  alu_result = id_ex_i.operand_a << shamt;
      ALU_SRL:  alu_result = id_ex_i.operand_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  alu_result = $unsigned($signed(id_ex_i.operand_a) >>> shamt);
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  alu_result = '0;
    endcase
    // Illegal words retire with zero
    if (id_ex_i.illegal) begin
      alu_result = '0;
    end
  end

  // Item as it will sit in EX/WB
  always_comb begin
    ex_wb_d.rd      = id_ex_i.rd;
    ex_wb_d.rd_we   = id_ex_i.rd_we;
    ex_wb_d.result  = alu_result;
    ex_wb_d.illegal = id_ex_i.illegal;
  end

  // Forwarded before it is registered
  assign fwd_ex_o = ex_wb_d;

  ////////////////////
  // EX/WB register
  ////////////////////
  assign ex_ready_o = !ex_valid_q || wb_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_q <= 1'b0;
    end else if (ex_ready_o) begin
      ex_valid_q <= id_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_valid_i && ex_ready_o) begin
      ex_wb_q <= ex_wb_d;
    end
  end

  assign ex_valid_o = ex_valid_q;
  assign ex_wb_o    = ex_wb_q;

endmodule

// ==== verilog/rv_id_stage.sv ====
// Decodes OP, OP-IMM and LUI only; other words leave as illegal with no register write
`timescale 1ns/1ps
module rv_id_stage (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Instruction stream
  input  logic                               instr_valid_i,
  output logic                               instr_ready_o,
  input  rv_core_pkg::instr_u                instr_i,
  // Register file read
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_b_i,
  // Forwarding from EX and WB
  input  rv_core_pkg::ex_wb_t                fwd_ex_i,
  input  rv_core_pkg::ex_wb_t                fwd_wb_i,
  input  logic                               fwd_ex_valid_i,
  input  logic                               fwd_wb_valid_i,
  // ID/EX handshake
  output logic                               id_valid_o,
  input  logic                               ex_ready_i,
  output rv_core_pkg::id_ex_t                id_ex_o
);
  import rv_core_pkg::*;

  // Instruction holding register
  logic            ir_valid_q;
  instr_u          ir_q;
  // ID/EX register
  logic            id_valid_q;
  id_ex_t          id_ex_q;
  id_ex_t          id_ex_d;
  logic            id_ready;
  // Resolved sources
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] imm_i;

  // Youngest valid writer wins, x0 never matches
  function automatic logic [XLEN-1:0] resolve_src(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0]       rf_data,
    input ex_wb_t                ex,
    input logic                  ex_v,
    input ex_wb_t                wb,
    input logic                  wb_v
  );
    logic [XLEN-1:0] val;
    val = rf_data;
    if (wb_v && wb.rd_we && (wb.rd != '0) && (wb.rd == addr)) begin
      val = wb.result;
    end
    // EX is younger, so it overrides WB
    if (ex_v && ex.rd_we && (ex.rd != '0) && (ex.rd == addr)) begin
      val = ex.result;
    end
    return val;
  endfunction

  ////////////////////
  // Register read
  ////////////////////
  assign rf_raddr_a_o = ir_q.r_type.rs1;
  assign rf_raddr_b_o = ir_q.r_type.rs2;
  assign rs1_val = resolve_src(ir_q.r_type.rs1, rf_rdata_a_i, fwd_ex_i, fwd_ex_valid_i,
                               fwd_wb_i, fwd_wb_valid_i);
  assign rs2_val = resolve_src(ir_q.r_type.rs2, rf_rdata_b_i, fwd_ex_i, fwd_ex_valid_i,
                               fwd_wb_i, fwd_wb_valid_i);

  // Sign-extended I immediate
  assign imm_i = {{(XLEN-12){ir_q.i_type.imm[11]}}, ir_q.i_type.imm};

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    id_ex_d           = '0;
    id_ex_d.alu_op    = ALU_ADD;
    id_ex_d.operand_a = rs1_val;
    id_ex_d.rd        = ir_q.r_type.rd;
    case (ir_q.r_type.opcode)
      OPCODE_OP: begin
        id_ex_d.operand_b = rs2_val;
        case ({ir_q.r_type.funct7, ir_q.r_type.funct3})
          {FUNCT7_BASE, 3'b000}: id_ex_d.alu_op = ALU_ADD;
          {FUNCT7_ALT,  3'b000}: id_ex_d.alu_op = ALU_SUB;
          {FUNCT7_BASE, 3'b001}: id_ex_d.alu_op = ALU_SLL;
          {FUNCT7_BASE, 3'b010}: id_ex_d.alu_op = ALU_SLT;
          {FUNCT7_BASE, 3'b011}: id_ex_d.alu_op = ALU_SLTU;
          {FUNCT7_BASE, 3'b100}: id_ex_d.alu_op = ALU_XOR;
          {FUNCT7_BASE, 3'b101}: id_ex_d.alu_op = ALU_SRL;
          {FUNCT7_ALT,  3'b101}: id_ex_d.alu_op = ALU_SRA;
          {FUNCT7_BASE, 3'b110}: id_ex_d.alu_op = ALU_OR;
          {FUNCT7_BASE, 3'b111}: id_ex_d.alu_op = ALU_AND;
          default:               id_ex_d.illegal = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        id_ex_d.operand_b = imm_i;
        // Shift immediates still carry funct7 in the upper imm bits
        case ({ir_q.r_type.funct7, ir_q.i_type.funct3}) inside
          {7'b???????, 3'b000}:  id_ex_d.alu_op = ALU_ADD;
          {7'b???????, 3'b010}:  id_ex_d.alu_op = ALU_SLT;
          {7'b???????, 3'b011}:  id_ex_d.alu_op = ALU_SLTU;
          {7'b???????, 3'b100}:  id_ex_d.alu_op = ALU_XOR;
          {7'b???????, 3'b110}:  id_ex_d.alu_op = ALU_OR;
          {7'b???????, 3'b111}:  id_ex_d.alu_op = ALU_AND;
          {FUNCT7_BASE, 3'b001}: id_ex_d.alu_op = ALU_SLL;
          {FUNCT7_BASE, 3'b101}: id_ex_d.alu_op = ALU_SRL;
          {FUNCT7_ALT,  3'b101}: id_ex_d.alu_op = ALU_SRA;
          default:               id_ex_d.illegal = 1'b1;
        endcase
      end
      OPCODE_LUI: begin
        // rs1 field is immediate here, so no source
        id_ex_d.operand_a = '0;
        id_ex_d.operand_b = {ir_q.i_type.imm, ir_q.i_type.rs1, ir_q.i_type.funct3, 12'b0};
      end
      default: begin
        id_ex_d.illegal = 1'b1;
      end
    endcase
    id_ex_d.rd_we = !id_ex_d.illegal;
  end

  ////////////////////
  // Handshake and registers
  ////////////////////
  // Each slot accepts when empty or draining
  assign id_ready      = !id_valid_q || ex_ready_i;
  assign instr_ready_o = !ir_valid_q || id_ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ir_valid_q <= 1'b0;
      id_valid_q <= 1'b0;
    end else begin
      if (instr_ready_o) begin
        ir_valid_q <= instr_valid_i;
      end
      if (id_ready) begin
        id_valid_q <= ir_valid_q;
      end
    end
  end

  // Payload only, qualified by the valids above
  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      ir_q <= instr_i;
    end
    if (ir_valid_q && id_ready) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_valid_o = id_valid_q;
  assign id_ex_o    = id_ex_q;

endmodule

// ==== verilog/rv_register_file.sv ====
// Two async read ports, one write port; x0 hardwired to zero, writes seen the next cycle
`timescale 1ns/1ps
module rv_register_file (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Read ports
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  // Write port
  input  logic                               we_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_core_pkg::XLEN-1:0]       wdata_i
);
  import rv_core_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // No write-through, same-cycle data comes from WB forwarding
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== verilog/rv_wb_stage.sv ====
// Purely combinational; commits rd only on the retire transfer, so a stall holds the write
`timescale 1ns/1ps
module rv_wb_stage (
  // EX/WB handshake
  input  logic                               ex_valid_i,
  output logic                               wb_ready_o,
  input  rv_core_pkg::ex_wb_t                ex_wb_i,
  // Retire stream
  output logic                               retire_valid_o,
  input  logic                               retire_ready_i,
  output rv_core_pkg::retire_t               retire_o,
  // Register file write
  output logic                               rf_we_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_core_pkg::XLEN-1:0]       rf_wdata_o,
  // Held item, for ID
  output rv_core_pkg::ex_wb_t                fwd_wb_o
);
  import rv_core_pkg::*;

  logic retire_fire;

  // Stall propagates back only when something is held
  assign wb_ready_o     = !ex_valid_i || retire_ready_i;
  assign retire_valid_o = ex_valid_i;
  assign retire_fire    = ex_valid_i && retire_ready_i;

  // External payload, field by field
  always_comb begin
    retire_o.rd      = ex_wb_i.rd;
    retire_o.rd_we   = ex_wb_i.rd_we;
    retire_o.result  = ex_wb_i.result;
    retire_o.illegal = ex_wb_i.illegal;
  end

  // Write port, x0 filtered in the register file
  assign rf_we_o    = retire_fire && ex_wb_i.rd_we;
  assign rf_waddr_o = ex_wb_i.rd;
  assign rf_wdata_o = ex_wb_i.result;

  assign fwd_wb_o = ex_wb_i;

endmodule

// ==== vlog.f ====
verilog/rv_core_pkg.sv
verilog/rv_register_file.sv
verilog/rv_id_stage.sv
verilog/rv_ex_stage.sv
verilog/rv_wb_stage.sv
verilog/rv_core.sv
tb/rv_core_assert.sv
tb/tb_rv_core.sv
